//--- build.f
+incdir+tb
source/zbus_pkg.sv
source/z80_ram.sv
source/zbus_arbiter.sv
source/mbus_decoder.sv
source/sound_bus_top.sv
tb/tb_sound_bus.sv

//--- source/mbus_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module mbus_decoder
	import zbus_pkg::*;
(
	input  wire                    MCLK,
	input  wire                    reset,

	// APB slave
	input  wire                    psel,
	input  wire                    penable,
	input  wire                    pwrite,
	input  wire [MBUS_ADDR_W-1:0]  paddr,
	input  wire [MBUS_DATA_W-1:0]  pwdata,
	output logic [MBUS_DATA_W-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr,

	// Sound bus request
	output logic                   zbus_sel,
	output logic                   zbus_we,
	output logic [ZBUS_ADDR_W-1:0] zbus_addr,
	output logic [ZBUS_DATA_W-1:0] zbus_wdata,
	input  wire [ZBUS_DATA_W-1:0]  zbus_rdata,
	input  wire                    zbus_ack,

	// Control flags
	output logic                   z80_busreq,
	output logic                   z80_reset_n
);

	logic       access;
	logic       sel_window;
	logic       sel_busreq;
	logic       sel_reset;
	logic       sel_none;
	logic       ctrl_wr;
	mbus_word_u wr_word;
	mbus_word_u rd_word;
	mbus_word_u ctrl_word;

	// -------------------------------------------------------------------------
	// Address decode
	// -------------------------------------------------------------------------
	assign access = psel & penable;

	always_comb begin
		sel_window = (paddr[MBUS_ADDR_W-1 -: 8] == ZBUS_WINDOW);
		sel_busreq = (paddr == CTRL_BUSREQ_ADDR);
		sel_reset  = (paddr == CTRL_RESET_ADDR);
		sel_none   = ~sel_window & ~sel_busreq & ~sel_reset;
	end

	// Register and unmapped transfers finish in the first access cycle
	assign pready  = access & (~sel_window | zbus_ack);
	assign pslverr = access & sel_none;

	// -------------------------------------------------------------------------
	// Control registers
	// -------------------------------------------------------------------------
	assign ctrl_wr = access & pwrite & (sel_busreq | sel_reset);

	// Z80 starts held in reset with the bus not requested
	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq  <= 1'b0;
			z80_reset_n <= 1'b0;
		end else if (ctrl_wr) begin
			if (sel_busreq) begin
				z80_busreq <= pwdata[CTRL_FLAG_BIT];
			end
			if (sel_reset) begin
				z80_reset_n <= pwdata[CTRL_FLAG_BIT];
			end
		end
	end

	// Busreq reads back inverted, as a "bus granted" flag
	always_comb begin
		ctrl_word.word = '0;
		if (sel_busreq) begin
			ctrl_word.word[CTRL_FLAG_BIT] = ~z80_busreq;
		end else begin
			ctrl_word.word[CTRL_FLAG_BIT] = z80_reset_n;
		end
	end

	// -------------------------------------------------------------------------
	// Sound bus window
	// -------------------------------------------------------------------------

	// Held through the access phase until the arbiter acks
	assign zbus_sel  = access & sel_window;
	assign zbus_we   = pwrite;
	assign zbus_addr = paddr[ZBUS_ADDR_W-1:0];

	// Even address uses the upper lane
	always_comb begin
		wr_word.word = pwdata;
		if (paddr[0]) begin
			zbus_wdata = wr_word.lane[0];
		end else begin
			zbus_wdata = wr_word.lane[1];
		end
	end

	// Returned byte shows up on both lanes
	always_comb begin
		rd_word.lane = {zbus_rdata, zbus_rdata};
	end

	// -------------------------------------------------------------------------
	// Read data
	// -------------------------------------------------------------------------
	always_comb begin
		if (sel_window) begin
			prdata = rd_word.word;
		end else if (sel_busreq | sel_reset) begin
			prdata = ctrl_word.word;
		end else begin
			prdata = '0;
		end
	end

endmodule

`default_nettype wire

//--- source/sound_bus_top.sv
`timescale 1ns/1ns
`default_nettype none

module sound_bus_top
	import zbus_pkg::*;
#(
	parameter int RAM_ADDR_W = ZRAM_ADDR_W
) (
	input  wire                    MCLK,
	input  wire                    reset,

	// APB from the main CPU side
	input  wire                    psel,
	input  wire                    penable,
	input  wire                    pwrite,
	input  wire [MBUS_ADDR_W-1:0]  paddr,
	input  wire [MBUS_DATA_W-1:0]  pwdata,
	output logic [MBUS_DATA_W-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr,

	// Z80 request port
	input  wire                    z80_req,
	input  wire                    z80_we,
	input  wire [ZBUS_ADDR_W-1:0]  z80_addr,
	input  wire [ZBUS_DATA_W-1:0]  z80_wdata,
	output logic [ZBUS_DATA_W-1:0] z80_rdata,
	output logic                   z80_ack
);

	// Decoder to arbiter
	logic                   zbus_sel;
	logic                   zbus_we;
	logic [ZBUS_ADDR_W-1:0] zbus_addr;
	logic [ZBUS_DATA_W-1:0] zbus_wdata;
	logic [ZBUS_DATA_W-1:0] zbus_rdata;
	logic                   zbus_ack;
	logic                   z80_busreq;
	logic                   z80_reset_n;

	// Arbiter to RAM
	logic [RAM_ADDR_W-1:0]  ram_addr;
	logic [ZBUS_DATA_W-1:0] ram_wdata;
	logic                   ram_we;
	logic [ZBUS_DATA_W-1:0] ram_rdata;

	mbus_decoder decoder_i (
		.MCLK        (MCLK),
		.reset       (reset),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.zbus_sel    (zbus_sel),
		.zbus_we     (zbus_we),
		.zbus_addr   (zbus_addr),
		.zbus_wdata  (zbus_wdata),
		.zbus_rdata  (zbus_rdata),
		.zbus_ack    (zbus_ack),
		.z80_busreq  (z80_busreq),
		.z80_reset_n (z80_reset_n)
	);

	zbus_arbiter #(
		.RAM_ADDR_W (RAM_ADDR_W)
	) arbiter_i (
		.MCLK        (MCLK),
		.reset       (reset),
		.zbus_sel    (zbus_sel),
		.zbus_we     (zbus_we),
		.zbus_addr   (zbus_addr),
		.zbus_wdata  (zbus_wdata),
		.zbus_rdata  (zbus_rdata),
		.zbus_ack    (zbus_ack),
		.z80_busreq  (z80_busreq),
		.z80_reset_n (z80_reset_n),
		.z80_req     (z80_req),
		.z80_we      (z80_we),
		.z80_addr    (z80_addr),
		.z80_wdata   (z80_wdata),
		.z80_rdata   (z80_rdata),
		.z80_ack     (z80_ack),
		.ram_addr    (ram_addr),
		.ram_wdata   (ram_wdata),
		.ram_we      (ram_we),
		.ram_rdata   (ram_rdata)
	);

	z80_ram #(
		.RAM_ADDR_W (RAM_ADDR_W)
	) ram_i (
		.MCLK  (MCLK),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.we    (ram_we),
		.rdata (ram_rdata)
	);

endmodule

`default_nettype wire

//--- source/z80_ram.sv
`timescale 1ns/1ns
`default_nettype none

module z80_ram
	import zbus_pkg::*;
#(
	parameter int RAM_ADDR_W = ZRAM_ADDR_W
) (
	input  wire                    MCLK,
	input  wire [RAM_ADDR_W-1:0]   addr,
	input  wire [ZBUS_DATA_W-1:0]  wdata,
	input  wire                    we,
	output logic [ZBUS_DATA_W-1:0] rdata
);

	localparam int DEPTH = 1 << RAM_ADDR_W;

	logic [ZBUS_DATA_W-1:0] mem [0:DEPTH-1];

	// Single port, read-before-write
	always_ff @(posedge MCLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

//--- source/zbus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module zbus_arbiter
	import zbus_pkg::*;
#(
	parameter int RAM_ADDR_W = ZRAM_ADDR_W
) (
	input  wire                    MCLK,
	input  wire                    reset,

	// Main-bus side request
	input  wire                    zbus_sel,
	input  wire                    zbus_we,
	input  wire [ZBUS_ADDR_W-1:0]  zbus_addr,
	input  wire [ZBUS_DATA_W-1:0]  zbus_wdata,
	output logic [ZBUS_DATA_W-1:0] zbus_rdata,
	output logic                   zbus_ack,

	// Control flags from the decoder
	input  wire                    z80_busreq,
	input  wire                    z80_reset_n,

	// Z80 side request
	input  wire                    z80_req,
	input  wire                    z80_we,
	input  wire [ZBUS_ADDR_W-1:0]  z80_addr,
	input  wire [ZBUS_DATA_W-1:0]  z80_wdata,
	output logic [ZBUS_DATA_W-1:0] z80_rdata,
	output logic                   z80_ack,

	// RAM port
	output logic [RAM_ADDR_W-1:0]  ram_addr,
	output logic [ZBUS_DATA_W-1:0] ram_wdata,
	output logic                   ram_we,
	input  wire [ZBUS_DATA_W-1:0]  ram_rdata
);

	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_READ   = 2'd1;
	localparam logic [1:0] ST_FINISH = 2'd2;

	localparam logic SRC_MBUS = 1'b0;
	localparam logic SRC_Z80  = 1'b1;

	// Bit 14 set means outside the RAM area
	localparam int RAM_SEL_BIT = 14;

	logic [1:0]             state;
	logic                   cur_src;
	logic                   cur_owned;
	logic [ZBUS_ADDR_W-1:0] cur_addr;
	logic [ZBUS_DATA_W-1:0] cur_wdata;
	logic [ZBUS_DATA_W-1:0] resp_byte;
	logic                   bus_free;
	logic                   z80_run;
	logic                   take_mbus;
	logic                   take_z80;

	// -------------------------------------------------------------------------
	// Ownership and request qualification
	// -------------------------------------------------------------------------
	assign bus_free = z80_busreq & z80_reset_n;
	assign z80_run  = z80_reset_n & ~z80_busreq;

	// A requester still holds its request during its own ack cycle
	assign take_mbus = zbus_sel & ~zbus_ack;
	assign take_z80  = z80_req & ~z80_ack & z80_run;

	assign ram_addr  = cur_addr[RAM_ADDR_W-1:0];
	assign ram_wdata = cur_wdata;

	// RAM data only for an owned access inside RAM
	assign resp_byte = (cur_owned & ~cur_addr[RAM_SEL_BIT]) ? ram_rdata : ZBUS_OPEN_BYTE;

	// -------------------------------------------------------------------------
	// State machine
	// -------------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		ram_we   <= 1'b0;
		zbus_ack <= 1'b0;
		z80_ack  <= 1'b0;
		if (reset) begin
			state   <= ST_IDLE;
			cur_src <= SRC_MBUS;
		end else begin
			case (state)
				ST_IDLE: begin
					// Main bus has priority
					if (take_mbus) begin
						cur_src <= SRC_MBUS;
						ram_we  <= zbus_we & bus_free & ~zbus_addr[RAM_SEL_BIT];
						state   <= ST_READ;
					end else if (take_z80) begin
						cur_src <= SRC_Z80;
						ram_we  <= z80_we & ~z80_addr[RAM_SEL_BIT];
						state   <= ST_READ;
					end
				end
				ST_READ: begin
					state <= ST_FINISH;
				end
				ST_FINISH: begin
					if (cur_src == SRC_MBUS) begin
						zbus_ack <= 1'b1;
					end else begin
						z80_ack <= 1'b1;
					end
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Request capture and response data
	always_ff @(posedge MCLK) begin
		if (state == ST_IDLE) begin
			if (take_mbus) begin
				cur_addr  <= zbus_addr;
				cur_wdata <= zbus_wdata;
				cur_owned <= bus_free;
			end else if (take_z80) begin
				cur_addr  <= z80_addr;
				cur_wdata <= z80_wdata;
				cur_owned <= 1'b1;
			end
		end
		if (state == ST_FINISH) begin
			if (cur_src == SRC_MBUS) begin
				zbus_rdata <= resp_byte;
			end else begin
				z80_rdata <= resp_byte;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/zbus_pkg.sv
`default_nettype none

package zbus_pkg;

	// -------------------------------------------------------------------------
	// Bus widths
	// -------------------------------------------------------------------------

	// Main CPU bus as seen through APB
	parameter int MBUS_ADDR_W = 24;
	parameter int MBUS_DATA_W = 16;

	// Sound CPU private bus
	parameter int ZBUS_ADDR_W = 15;
	parameter int ZBUS_DATA_W = 8;

	// 8 KB sound RAM
	parameter int ZRAM_ADDR_W = 13;

	// -------------------------------------------------------------------------
	// Address map
	// -------------------------------------------------------------------------

	// Upper byte of the A00000-A0FFFF window
	parameter logic [7:0] ZBUS_WINDOW = 8'hA0;

	// Control registers on the main bus
	parameter logic [MBUS_ADDR_W-1:0] CTRL_BUSREQ_ADDR = 24'hA11100;
	parameter logic [MBUS_ADDR_W-1:0] CTRL_RESET_ADDR  = 24'hA11200;

	// Both control registers live in this data bit
	parameter int CTRL_FLAG_BIT = 8;

	// Floating sound bus value
	parameter logic [ZBUS_DATA_W-1:0] ZBUS_OPEN_BYTE = 8'hFF;

	// -------------------------------------------------------------------------
	// Main-bus data word
	// -------------------------------------------------------------------------

	// lane[1] is the upper byte (even address), lane[0] the lower byte (odd)
	typedef union packed {
		logic [MBUS_DATA_W-1:0]      word;
		logic [1:0][ZBUS_DATA_W-1:0] lane;
	} mbus_word_u;

endpackage

`default_nettype wire

//--- tb/zbus_model.svh
`ifndef ZBUS_MODEL_SVH
`define ZBUS_MODEL_SVH

// Reference state of the control flags and the sound RAM
logic                   m_busreq;
logic                   m_reset_n;
logic [ZBUS_DATA_W-1:0] m_ram [0:(1 << ZRAM_ADDR_W)-1];

// Z80 held in reset, bus not requested
task automatic model_reset();
	m_busreq = 1'b0;
	m_reset_n = 1'b0;
endtask

function automatic logic model_z80_running();
	return m_reset_n && !m_busreq;
endfunction

// One sound-bus access by either port
task automatic model_zbus(input logic we, input logic owned,
		input logic [ZBUS_ADDR_W-1:0] addr, input logic [ZBUS_DATA_W-1:0] wdata,
		output logic [ZBUS_DATA_W-1:0] rdata);
	rdata = ZBUS_OPEN_BYTE;
	// Bit 14 clear is RAM, mirrored every 8 KB
	if (owned && !addr[14]) begin
		if (we) begin
			m_ram[addr[ZRAM_ADDR_W-1:0]] = wdata;
		end else begin
			rdata = m_ram[addr[ZRAM_ADDR_W-1:0]];
		end
	end
endtask

// Main-bus transfer; expected data is meaningful for reads only
task automatic model_apb(input logic we, input logic [MBUS_ADDR_W-1:0] addr,
		input logic [MBUS_DATA_W-1:0] wdata, output logic [MBUS_DATA_W-1:0] exp_data,
		output logic exp_err);
	mbus_word_u             w;
	logic [ZBUS_DATA_W-1:0] wr_byte;
	logic [ZBUS_DATA_W-1:0] rd_byte;
	w.word = wdata;
	exp_data = '0;
	exp_err = 1'b0;
	if (addr[MBUS_ADDR_W-1 -: 8] == ZBUS_WINDOW) begin
		// Even byte address takes the upper lane
		wr_byte = addr[0] ? w.lane[0] : w.lane[1];
		model_zbus(we, m_busreq && m_reset_n, addr[ZBUS_ADDR_W-1:0], wr_byte, rd_byte);
		w.lane[1] = rd_byte;
		w.lane[0] = rd_byte;
		exp_data = w.word;
	end else if (addr == CTRL_BUSREQ_ADDR) begin
		if (we) begin
			m_busreq = wdata[CTRL_FLAG_BIT];
		end
		exp_data[CTRL_FLAG_BIT] = !m_busreq;
	end else if (addr == CTRL_RESET_ADDR) begin
		if (we) begin
			m_reset_n = wdata[CTRL_FLAG_BIT];
		end
		exp_data[CTRL_FLAG_BIT] = m_reset_n;
	end else begin
		exp_err = 1'b1;
	end
endtask

`endif

//--- tb/tb_sound_bus.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sound_bus
	import zbus_pkg::*;
();

	localparam int NUM_FILL     = 1 << ZRAM_ADDR_W;
	localparam int NUM_DIRECTED = 80;
	localparam int NUM_RANDOM   = 400;
	localparam int WATCHDOG_NS  = (NUM_FILL + NUM_DIRECTED + NUM_RANDOM) * 20 * 100;

	logic                   MCLK;
	logic                   reset;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [MBUS_ADDR_W-1:0] paddr;
	logic [MBUS_DATA_W-1:0] pwdata;
	logic [MBUS_DATA_W-1:0] prdata;
	logic                   pready;
	logic                   pslverr;
	logic                   z80_req;
	logic                   z80_we;
	logic [ZBUS_ADDR_W-1:0] z80_addr;
	logic [ZBUS_DATA_W-1:0] z80_wdata;
	logic [ZBUS_DATA_W-1:0] z80_rdata;
	logic                   z80_ack;

	integer seed;
	int     checks;
	int     errors;

	`include "zbus_model.svh"

	sound_bus_top dut_i (
		.MCLK      (MCLK),
		.reset     (reset),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.z80_req   (z80_req),
		.z80_we    (z80_we),
		.z80_addr  (z80_addr),
		.z80_wdata (z80_wdata),
		.z80_rdata (z80_rdata),
		.z80_ack   (z80_ack)
	);

	always #50 MCLK = ~MCLK;

	// ------------------------------------------------------------------------
	// Checking and drivers
	// ------------------------------------------------------------------------
	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Pattern mixes all RAM address bits
	function automatic logic [7:0] fill_byte(input logic [12:0] a);
		return a[7:0] ^ {a[12:8], 3'b110};
	endfunction

	task automatic apb_xfer(input logic we, input logic [MBUS_ADDR_W-1:0] addr,
			input logic [MBUS_DATA_W-1:0] wdata, output logic [MBUS_DATA_W-1:0] rdata,
			output logic err, output int waits);
		@(posedge MCLK);
		#5;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = we;
		paddr = addr;
		pwdata = wdata;
		@(posedge MCLK);
		#5;
		penable = 1'b1;
		waits = 0;
		@(negedge MCLK);
		while (!pready) begin
			waits++;
			@(negedge MCLK);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge MCLK);
		#5;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_check(input logic we, input logic [MBUS_ADDR_W-1:0] addr,
			input logic [MBUS_DATA_W-1:0] wdata);
		logic [MBUS_DATA_W-1:0] got;
		logic                   err;
		int                     waits;
		logic [MBUS_DATA_W-1:0] exp_data;
		logic                   exp_err;
		model_apb(we, addr, wdata, exp_data, exp_err);
		apb_xfer(we, addr, wdata, got, err, waits);
		check("pslverr", err, exp_err);
		// Register and unmapped transfers end in the first access cycle
		if (addr[MBUS_ADDR_W-1 -: 8] != ZBUS_WINDOW) begin
			check("pready wait cycles", waits[15:0], 16'd0);
		end
		if (!we) begin
			check("prdata", got, exp_data);
		end
	endtask

	task automatic z80_start(input logic we, input logic [ZBUS_ADDR_W-1:0] addr,
			input logic [ZBUS_DATA_W-1:0] wdata);
		@(posedge MCLK);
		#5;
		z80_req = 1'b1;
		z80_we = we;
		z80_addr = addr;
		z80_wdata = wdata;
	endtask

	task automatic z80_finish(output logic [ZBUS_DATA_W-1:0] rdata);
		@(negedge MCLK);
		while (!z80_ack) begin
			@(negedge MCLK);
		end
		rdata = z80_rdata;
		@(posedge MCLK);
		#5;
		z80_req = 1'b0;
	endtask

	task automatic z80_check(input logic we, input logic [ZBUS_ADDR_W-1:0] addr,
			input logic [ZBUS_DATA_W-1:0] wdata);
		logic [ZBUS_DATA_W-1:0] got;
		logic [ZBUS_DATA_W-1:0] exp;
		z80_start(we, addr, wdata);
		z80_finish(got);
		model_zbus(we, 1'b1, addr, wdata, exp);
		if (!we) begin
			check("z80_rdata", got, exp);
		end
	endtask

	// Request while halted must stall until the control write frees the Z80
	task automatic z80_halted_check(input logic we, input logic [ZBUS_ADDR_W-1:0] addr,
			input logic [ZBUS_DATA_W-1:0] wdata, input logic [MBUS_ADDR_W-1:0] ctrl_addr,
			input logic [MBUS_DATA_W-1:0] ctrl_data);
		logic [ZBUS_DATA_W-1:0] got;
		logic [ZBUS_DATA_W-1:0] exp;
		z80_start(we, addr, wdata);
		repeat (50) begin
			@(negedge MCLK);
			if (z80_ack) begin
				errors++;
				$display("Error at %0t ns: Z80 request acknowledged while halted", $time);
			end
		end
		apb_check(1'b1, ctrl_addr, ctrl_data);
		z80_finish(got);
		model_zbus(we, 1'b1, addr, wdata, exp);
		if (!we) begin
			check("z80_rdata", got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// Watchdog
	// ------------------------------------------------------------------------
	initial begin
		#(WATCHDOG_NS);
		$display("Error: timeout, the run did not end within %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		int          a;
		int          op;
		logic [31:0] rnd;
		MCLK = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		z80_req = 1'b0;
		z80_we = 1'b0;
		z80_addr = '0;
		z80_wdata = '0;
		seed = 57101;
		checks = 0;
		errors = 0;
		model_reset();
		repeat (4) @(posedge MCLK);
		#5;
		reset = 1'b0;
		check("pready", pready, 1'b0);
		check("z80_ack", z80_ack, 1'b0);

		// Control registers with all other bits reading zero
		apb_check(1'b0, CTRL_BUSREQ_ADDR, 16'h0000);
		apb_check(1'b0, CTRL_RESET_ADDR, 16'h0000);
		apb_check(1'b1, CTRL_RESET_ADDR, 16'hFEFF);
		apb_check(1'b0, CTRL_RESET_ADDR, 16'h0000);
		apb_check(1'b1, CTRL_BUSREQ_ADDR, 16'h0100);
		apb_check(1'b0, CTRL_BUSREQ_ADDR, 16'h0000);
		apb_check(1'b1, CTRL_BUSREQ_ADDR, 16'hFEFF);
		apb_check(1'b1, CTRL_RESET_ADDR, 16'h0100);
		apb_check(1'b0, CTRL_RESET_ADDR, 16'h0000);

		// Fill RAM from the running Z80 and read back through the mirror
		for (a = 0; a < NUM_FILL; a++) begin
			z80_check(1'b1, a[14:0], fill_byte(a[12:0]));
		end
		z80_check(1'b0, 15'h0000, 8'h00);
		z80_check(1'b0, 15'h3FFF, 8'h00);
		z80_check(1'b0, 15'h2345, 8'h00);
		z80_check(1'b0, 15'h7FFF, 8'h00);
		z80_check(1'b1, 15'h4345, 8'h77);
		z80_check(1'b0, 15'h0345, 8'h00);

		// APB without the bus, then bus requested but Z80 still in reset
		apb_check(1'b0, 24'hA00010, 16'h0000);
		apb_check(1'b1, 24'hA00010, 16'h5A5A);
		apb_check(1'b1, CTRL_BUSREQ_ADDR, 16'h0100);
		apb_check(1'b1, CTRL_RESET_ADDR, 16'h0000);
		apb_check(1'b0, 24'hA00011, 16'h0000);
		apb_check(1'b1, 24'hA00011, 16'hA5A5);
		apb_check(1'b1, CTRL_RESET_ADDR, 16'h0100);
		apb_check(1'b0, 24'hA00010, 16'h0000);
		apb_check(1'b0, 24'hA00011, 16'h0000);

		// Lanes, aliasing and the area above RAM with the bus owned
		apb_check(1'b1, 24'hA00200, 16'hABCD);
		apb_check(1'b1, 24'hA00201, 16'h1234);
		apb_check(1'b0, 24'hA00200, 16'h0000);
		apb_check(1'b0, 24'hA00201, 16'h0000);
		apb_check(1'b0, 24'hA02200, 16'h0000);
		apb_check(1'b1, 24'hA03FFF, 16'h00C3);
		apb_check(1'b0, 24'hA01FFF, 16'h0000);
		apb_check(1'b0, 24'hA0C200, 16'h0000);
		apb_check(1'b1, 24'hA04200, 16'h1111);
		apb_check(1'b0, 24'hA04200, 16'h0000);
		apb_check(1'b0, 24'hA00200, 16'h0000);

		// Z80 halted by bus request, then by reset
		z80_halted_check(1'b0, 15'h0200, 8'h00, CTRL_BUSREQ_ADDR, 16'h0000);
		z80_check(1'b1, 15'h0300, 8'h3C);
		apb_check(1'b1, CTRL_RESET_ADDR, 16'h0000);
		z80_halted_check(1'b1, 15'h0301, 8'hC3, CTRL_RESET_ADDR, 16'h0100);
		z80_check(1'b0, 15'h0301, 8'h00);
		z80_check(1'b0, 15'h2300, 8'h00);

		// Unmapped addresses
		apb_check(1'b0, 24'h000000, 16'h0000);
		apb_check(1'b0, 24'hA11101, 16'h0000);
		apb_check(1'b1, 24'hA10000, 16'hFFFF);
		apb_check(1'b0, 24'hFFFFFF, 16'h0000);

		// Random mixed traffic
		for (a = 0; a < NUM_RANDOM; a++) begin
			op = $unsigned($random(seed)) % 8;
			rnd = $random(seed);
			case (op)
				0: apb_check(1'b1, rnd[24] ? CTRL_BUSREQ_ADDR : CTRL_RESET_ADDR, rnd[15:0]);
				1: apb_check(1'b0, rnd[24] ? CTRL_BUSREQ_ADDR : CTRL_RESET_ADDR, 16'h0000);
				2, 3: apb_check(1'b0, {ZBUS_WINDOW, rnd[15:0]}, 16'h0000);
				4: apb_check(1'b1, {ZBUS_WINDOW, rnd[15:0]}, rnd[31:16]);
				5: apb_check(rnd[31], rnd[23:0], rnd[15:0]);
				default: begin
					if (model_z80_running()) begin
						z80_check(rnd[31], rnd[14:0], rnd[23:16]);
					end else begin
						apb_check(1'b0, {ZBUS_WINDOW, rnd[15:0]}, 16'h0000);
					end
				end
			endcase
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
